//--- source/forthAlu_params.svh
`ifndef FORTHALU_PARAMS_SVH
`define FORTHALU_PARAMS_SVH

// Datapath widths
`define ALU_WIDTH 16
`define ALU_SHW 4 // Shift, rotate and bit-position amount

// Opcode codes
`define ALU_OPX_MOV 4'd0
`define ALU_OPX_ADD 4'd1
`define ALU_OPX_SUB 4'd2
`define ALU_OPX_MUL 4'd3
`define ALU_OPX_OR 4'd4
`define ALU_OPX_AND 4'd5
`define ALU_OPX_XOR 4'd6
`define ALU_OPX_SL 4'd7
`define ALU_OPX_SR 4'd8
`define ALU_OPX_SRA 4'd9
`define ALU_OPX_ROT 4'd10
`define ALU_OPX_BIT 4'd11
`define ALU_OPX_SET 4'd12
`define ALU_OPX_CLR 4'd13
`define ALU_OPX_CMP 4'd14 // Subtract without write-back
`define ALU_OPX_SEX 4'd15

`endif

//--- source/aluPkg.sv
`default_nettype none

`include "forthAlu_params.svh"

package aluPkg;

	typedef logic signed [`ALU_WIDTH-1:0] word_t; // Operand or result word
	typedef logic [3:0] aluOp_t; // Opcode
	typedef logic [3:0] aluFlags_t; // {sign, carry, zero, parity}

	// Input side handshake
	typedef enum logic [1:0] {
		issueIdle,
		issueHeld, // Operands captured, ack not yet raised
		issueRelease // Waiting for req to drop
	} issueState_t;

	// Output side handshake
	typedef enum logic [1:0] {
		retireEmpty,
		retireOffer, // Result offered to consumer
		retireDrain // Waiting for ack to drop
	} retireState_t;

endpackage

`default_nettype wire

//--- source/aluIssue.sv
`timescale 1ns/1ps
`default_nettype none

module aluIssue (
	input  logic           clk,
	input  logic           rstN,
	input  logic           opReq,
	input  aluPkg::aluOp_t opCode,
	input  aluPkg::word_t  opA,
	input  aluPkg::word_t  opB,
	input  logic           retireFree,
	output logic           opAck,
	output logic           issueStrobe,
	output aluPkg::aluOp_t curOp,
	output aluPkg::word_t  curA,
	output aluPkg::word_t  curB
);
	import aluPkg::*;

	issueState_t state;
	logic capture;

	// New op only when idle and the retire slot is empty
	assign capture = (state == issueIdle) && opReq && retireFree;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= issueIdle;
			opAck <= 1'b0;
			issueStrobe <= 1'b0;
		end else begin
			issueStrobe <= capture; // One cycle pulse
			case (state)
				issueIdle: begin
					if (capture) begin
						state <= issueHeld;
					end
				end
				issueHeld: begin
					opAck <= 1'b1; // Edge after capture
					state <= issueRelease;
				end
				issueRelease: begin
					if (!opReq) begin
						opAck <= 1'b0;
						state <= issueIdle;
					end
				end
				default: begin
					opAck <= 1'b0;
					state <= issueIdle;
				end
			endcase
		end
	end

	// Operand registers stay put until the next capture
	always_ff @(posedge clk) begin
		if (capture) begin
			curOp <= opCode;
			curA <= opA;
			curB <= opB;
		end
	end

	strobeSingle: assert property (@(posedge clk) disable iff (!rstN)
		issueStrobe |=> !issueStrobe)
		else $error("issueStrobe high on two consecutive cycles");

	// Ack may only rise in answer to a request seen high
	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(opAck) |-> $past(opReq))
		else $error("opAck rose without opReq");

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "forthAlu_params.svh"

module alu (
	input  aluPkg::aluOp_t    curOp,
	input  aluPkg::word_t     curA,
	input  aluPkg::word_t     curB,
	output aluPkg::word_t     aluResult,
	output aluPkg::aluFlags_t aluFlags,
	output logic              aluWrite
);
	import aluPkg::*;

	localparam logic [`ALU_WIDTH-1:0] unitBit = 1;
	localparam logic [`ALU_WIDTH-1:0] allOnes = '1;

	logic [`ALU_SHW-1:0] shamt;
	logic [`ALU_WIDTH:0] wideSum; // Carry in the top bit
	logic [`ALU_WIDTH:0] wideDiff; // Borrow in the top bit
	logic [`ALU_WIDTH:0] wideShl;
	logic signed [2*`ALU_WIDTH-1:0] product;
	logic [2*`ALU_WIDTH-1:0] rotWide;
	logic [`ALU_WIDTH-1:0] bitMask;
	logic [`ALU_WIDTH-1:0] extMask;
	logic extSign;

	word_t res;
	logic carry;
	logic ovfl;
	logic arithmetic;
	logic zero;
	logic sign;
	logic parity;

	assign shamt = curB[`ALU_SHW-1:0];

	assign wideSum = {1'b0, curA} + {1'b0, curB};
	assign wideDiff = {1'b0, curA} - {1'b0, curB};
	assign wideShl = {1'b0, curA} << shamt;
	assign product = (2*`ALU_WIDTH)'(curA) * (2*`ALU_WIDTH)'(curB); // Signed 32-bit product
	assign rotWide = {curA, curA} >> shamt;
	assign bitMask = unitBit << shamt;
	assign extMask = allOnes << shamt;
	assign extSign = |(curA & bitMask); // Bit that SEX copies upward

	always_comb begin
		res = curB;
		carry = 1'b0;
		ovfl = 1'b0;
		arithmetic = 1'b0;
		case (curOp)
			`ALU_OPX_MOV: begin
				res = curB; // Copies operand B
			end
			`ALU_OPX_ADD: begin
				res = wideSum[`ALU_WIDTH-1:0];
				carry = wideSum[`ALU_WIDTH];
				arithmetic = 1'b1;
			end
			`ALU_OPX_SUB: begin
				res = wideDiff[`ALU_WIDTH-1:0];
				carry = wideDiff[`ALU_WIDTH];
				arithmetic = 1'b1;
			end
			`ALU_OPX_MUL: begin
				res = product[`ALU_WIDTH-1:0];
				ovfl = |product[2*`ALU_WIDTH-1:`ALU_WIDTH]; // Any upper bit set
				arithmetic = 1'b1;
			end
			`ALU_OPX_OR: begin
				res = curA | curB;
			end
			`ALU_OPX_AND: begin
				res = curA & curB;
			end
			`ALU_OPX_XOR: begin
				res = curA ^ curB;
			end
			`ALU_OPX_SL: begin
				res = wideShl[`ALU_WIDTH-1:0];
				carry = wideShl[`ALU_WIDTH]; // Last bit shifted out
			end
			`ALU_OPX_SR: begin
				res = $unsigned(curA) >> shamt;
			end
			`ALU_OPX_SRA: begin
				res = curA >>> shamt; // Keeps the sign
			end
			`ALU_OPX_ROT: begin
				res = rotWide[`ALU_WIDTH-1:0]; // Rotate right
			end
			`ALU_OPX_BIT: begin
				res = curA & bitMask;
			end
			`ALU_OPX_SET: begin
				res = curA | bitMask;
			end
			`ALU_OPX_CLR: begin
				res = curA & ~bitMask;
			end
			`ALU_OPX_CMP: begin
				res = wideDiff[`ALU_WIDTH-1:0]; // Flags only without write-back
				arithmetic = 1'b1;
			end
			`ALU_OPX_SEX: begin
				if (extSign) begin
					res = curA | extMask;
				end else begin
					res = curA & ~extMask;
				end
				arithmetic = 1'b1;
			end
			default: begin
				res = curB;
			end
		endcase
	end

	assign zero = (res == '0);
	assign sign = res[`ALU_WIDTH-1];
	// Parity reports overflow for the arithmetic group
	assign parity = arithmetic ? ovfl : res[0];

	assign aluResult = res;
	assign aluFlags = {sign, carry, zero, parity};
	assign aluWrite = (curOp != `ALU_OPX_CMP);

endmodule

`default_nettype wire

//--- source/aluRetire.sv
`timescale 1ns/1ps
`default_nettype none

module aluRetire (
	input  logic              clk,
	input  logic              rstN,
	input  logic              issueStrobe,
	input  aluPkg::word_t     aluResult,
	input  aluPkg::aluFlags_t aluFlags,
	input  logic              aluWrite,
	input  logic              resAck,
	output logic              retireFree,
	output logic              resReq,
	output aluPkg::word_t     result,
	output aluPkg::aluFlags_t flags,
	output logic              writeBack
);
	import aluPkg::*;

	retireState_t state;
	logic load;

	assign load = (state == retireEmpty) && issueStrobe;
	assign retireFree = (state == retireEmpty); // Slot free for the next op

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= retireEmpty;
			resReq <= 1'b0;
		end else begin
			case (state)
				retireEmpty: begin
					if (load) begin
						resReq <= 1'b1; // Same edge as the latch
						state <= retireOffer;
					end
				end
				retireOffer: begin
					if (resAck) begin
						resReq <= 1'b0;
						state <= retireDrain;
					end
				end
				retireDrain: begin
					if (!resAck) begin
						state <= retireEmpty;
					end
				end
				default: begin
					resReq <= 1'b0;
					state <= retireEmpty;
				end
			endcase
		end
	end

	// Output registers
	always_ff @(posedge clk) begin
		if (load) begin
			result <= aluResult;
			flags <= aluFlags;
			writeBack <= aluWrite;
		end
	end

	resultStable: assert property (@(posedge clk) disable iff (!rstN)
		resReq && $past(resReq) |-> $stable(result) && $stable(flags))
		else $error("result changed while resReq was high");

	// Issue side must respect back-pressure
	noIssueWhenBusy: assert property (@(posedge clk) disable iff (!rstN)
		issueStrobe |-> retireFree)
		else $error("issueStrobe arrived while retire slot was busy");

endmodule

`default_nettype wire

//--- source/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input  logic              clk,
	input  logic              rstN,
	input  logic              opReq,
	input  aluPkg::aluOp_t    opCode,
	input  aluPkg::word_t     opA,
	input  aluPkg::word_t     opB,
	output logic              opAck,
	output logic              resReq,
	input  logic              resAck,
	output aluPkg::word_t     result,
	output aluPkg::aluFlags_t flags,
	output logic              writeBack
);
	import aluPkg::*;

	aluOp_t curOp;
	word_t curA;
	word_t curB;
	logic issueStrobe;
	logic retireFree;
	word_t aluResult;
	aluFlags_t aluFlags;
	logic aluWrite;

	aluIssue i_aluIssue (
		.clk(clk),
		.rstN(rstN),
		.opReq(opReq),
		.opCode(opCode),
		.opA(opA),
		.opB(opB),
		.retireFree(retireFree),
		.opAck(opAck),
		.issueStrobe(issueStrobe),
		.curOp(curOp),
		.curA(curA),
		.curB(curB)
	);

	alu i_alu (
		.curOp(curOp),
		.curA(curA),
		.curB(curB),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.aluWrite(aluWrite)
	);

	aluRetire i_aluRetire (
		.clk(clk),
		.rstN(rstN),
		.issueStrobe(issueStrobe),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.aluWrite(aluWrite),
		.resAck(resAck),
		.retireFree(retireFree),
		.resReq(resReq),
		.result(result),
		.flags(flags),
		.writeBack(writeBack)
	);

endmodule

`default_nettype wire

//--- tb/aluRef.svh
`ifndef ALUREF_SVH
`define ALUREF_SVH

`include "forthAlu_params.svh"

// Expected result, flags and write-back for one operation
function automatic void aluModel(input logic [3:0] op, input logic [15:0] a,
	input logic [15:0] b, output logic [15:0] res, output logic [3:0] flg,
	output logic wb);
	logic [3:0] n;
	int amt;
	int i;
	int s;
	logic [15:0] mask;
	logic cy;
	logic ov;
	logic arith;
	n = b[3:0];
	amt = int'(n);
	s = 0;
	res = a;
	mask = 16'hFFFF;
	cy = 1'b0;
	ov = 1'b0;
	arith = 1'b0;
	case (op)
		`ALU_OPX_MOV: begin
			res = b;
		end
		`ALU_OPX_ADD: begin
			s = int'(a) + int'(b);
			res = s[15:0];
			cy = s[16]; // Unsigned carry out
			arith = 1'b1;
		end
		`ALU_OPX_SUB: begin
			s = int'(a) - int'(b);
			res = s[15:0];
			cy = (a < b); // Borrow
			arith = 1'b1;
		end
		`ALU_OPX_MUL: begin
			s = int'($signed(a)) * int'($signed(b));
			res = s[15:0];
			ov = (s[31:16] != 16'h0000);
			arith = 1'b1;
		end
		`ALU_OPX_OR: begin
			res = a | b;
		end
		`ALU_OPX_AND: begin
			res = a & b;
		end
		`ALU_OPX_XOR: begin
			res = a ^ b;
		end
		`ALU_OPX_SL: begin
			for (i = 0; i < amt; i++) begin
				cy = res[15]; // Bit leaving on the left
				res = {res[14:0], 1'b0};
			end
		end
		`ALU_OPX_SR: begin
			for (i = 0; i < amt; i++) begin
				res = {1'b0, res[15:1]};
			end
		end
		`ALU_OPX_SRA: begin
			for (i = 0; i < amt; i++) begin
				res = {res[15], res[15:1]};
			end
		end
		`ALU_OPX_ROT: begin
			for (i = 0; i < amt; i++) begin
				res = {res[0], res[15:1]}; // One step right
			end
		end
		`ALU_OPX_BIT: begin
			res = 16'h0000;
			res[n] = a[n];
		end
		`ALU_OPX_SET: begin
			res[n] = 1'b1;
		end
		`ALU_OPX_CLR: begin
			res[n] = 1'b0;
		end
		`ALU_OPX_CMP: begin
			s = int'(a) - int'(b);
			res = s[15:0];
			arith = 1'b1;
		end
		`ALU_OPX_SEX: begin
			for (i = 0; i <= amt; i++) begin
				mask = mask << 1; // Bits above the sign position
			end
			res = a[n] ? (a | mask) : (a & ~mask);
			arith = 1'b1;
		end
		default: begin
			res = b;
		end
	endcase
	flg = {res[15], cy, res == 16'h0000, arith ? ov : res[0]};
	wb = (op != `ALU_OPX_CMP);
endfunction

function automatic string opName(input logic [3:0] op);
	case (op)
		`ALU_OPX_MOV: return "MOV";
		`ALU_OPX_ADD: return "ADD";
		`ALU_OPX_SUB: return "SUB";
		`ALU_OPX_MUL: return "MUL";
		`ALU_OPX_OR: return "OR";
		`ALU_OPX_AND: return "AND";
		`ALU_OPX_XOR: return "XOR";
		`ALU_OPX_SL: return "SL";
		`ALU_OPX_SR: return "SR";
		`ALU_OPX_SRA: return "SRA";
		`ALU_OPX_ROT: return "ROT";
		`ALU_OPX_BIT: return "BIT";
		`ALU_OPX_SET: return "SET";
		`ALU_OPX_CLR: return "CLR";
		`ALU_OPX_CMP: return "CMP";
		default: return "SEX";
	endcase
endfunction

`endif

//--- tb/aluUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "forthAlu_params.svh"

module aluUnit_tb;
	import aluPkg::*;

	localparam int timeoutCycles = 4000; // Room for some 300 operations of about eleven cycles each

	logic clk;
	logic rstN;
	logic opReq;
	aluOp_t opCode;
	word_t opA;
	word_t opB;
	logic opAck;
	logic resReq;
	logic resAck;
	word_t result;
	aluFlags_t flags;
	logic writeBack;
	logic holdAckLow; // Second op must not be acked yet
	int cycleCount;

	`include "aluRef.svh"

	aluUnit i_aluUnit (
		.clk(clk),
		.rstN(rstN),
		.opReq(opReq),
		.opCode(opCode),
		.opA(opA),
		.opB(opB),
		.opAck(opAck),
		.resReq(resReq),
		.resAck(resAck),
		.result(result),
		.flags(flags),
		.writeBack(writeBack)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// Watchdog on the whole run
	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Simulation timed out after %0d cycles", cycleCount);
		$display("Some tests failed");
		$fatal(1, "Timeout");
	end

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// One clock edge plus the back-pressure watch
	task automatic tick();
		@(posedge clk);
		if (holdAckLow) begin
			checkValue("backPressure opAck low", 16'h0000, 16'(opAck));
		end
	endtask

	task automatic raiseOp(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
		tick();
		opReq <= 1'b1;
		opCode <= op;
		opA <= a;
		opB <= b;
	endtask

	task automatic finishOp();
		tick();
		while (!opAck) begin
			tick();
		end
		tick(); // Keep req up one more cycle
		checkValue("opAck held while opReq high", 16'h0001, 16'(opAck));
		opReq <= 1'b0;
		while (opAck) begin
			tick();
		end
	endtask

	task automatic sendOp(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
		raiseOp(op, a, b);
		finishOp();
	endtask

	task automatic takeResult(output logic [15:0] res, output logic [3:0] flg,
		output logic wb);
		tick();
		while (!resReq) begin
			tick();
		end
		res = result;
		flg = flags;
		wb = writeBack;
		tick();
		checkValue("resReq held before resAck", 16'h0001, 16'(resReq));
		checkValue("result stable before resAck", res, result);
		resAck <= 1'b1;
		tick();
		checkValue("resReq high when resAck rose", 16'h0001, 16'(resReq));
		while (resReq) begin
			tick();
		end
		resAck <= 1'b0;
	endtask

	task automatic checkResult(input string name, input logic [3:0] op,
		input logic [15:0] a, input logic [15:0] b, input logic [15:0] gotRes,
		input logic [3:0] gotFlags, input logic gotWb);
		logic [15:0] expRes;
		logic [3:0] expFlags;
		logic expWb;
		aluModel(op, a, b, expRes, expFlags, expWb);
		checkValue({name, " result"}, expRes, gotRes);
		checkValue({name, " flags"}, 16'(expFlags), 16'(gotFlags));
		checkValue({name, " writeBack"}, 16'(expWb), 16'(gotWb));
	endtask

	task automatic runOp(input string tag, input logic [3:0] op, input logic [15:0] a,
		input logic [15:0] b);
		logic [15:0] gotRes;
		logic [3:0] gotFlags;
		logic gotWb;
		string name;
		name = $sformatf("%s %s a=%h b=%h", tag, opName(op), a, b);
		sendOp(op, a, b);
		takeResult(gotRes, gotFlags, gotWb);
		checkResult(name, op, a, b, gotRes, gotFlags, gotWb);
	endtask

	// Corner operand pairs whose B low nibble covers shifts of 0 and 15
	task automatic cornerOperands(input int k, output logic [15:0] a, output logic [15:0] b);
		case (k)
			0: begin
				a = 16'h0000;
				b = 16'h0000;
			end
			1: begin
				a = 16'hFFFF;
				b = 16'h0001;
			end
			2: begin
				a = 16'h8000;
				b = 16'h000F;
			end
			3: begin
				a = 16'h7FFF;
				b = 16'h0002;
			end
			4: begin
				a = 16'h1234;
				b = 16'hFFFF;
			end
			default: begin
				a = 16'h8000; // MUL overflow
				b = 16'h8000;
			end
		endcase
	endtask

	task automatic testReset();
		tick();
		checkValue("reset opAck", 16'h0000, 16'(opAck));
		checkValue("reset resReq", 16'h0000, 16'(resReq));
	endtask

	task automatic testCorners();
		logic [15:0] a;
		logic [15:0] b;
		int op;
		int k;
		for (op = 0; op < 16; op++) begin
			for (k = 0; k < 6; k++) begin
				cornerOperands(k, a, b);
				runOp("corner", 4'(op), a, b);
			end
		end
	endtask

	task automatic testLatency();
		int cycles;
		logic [15:0] gotRes;
		logic [3:0] gotFlags;
		logic gotWb;
		raiseOp(`ALU_OPX_ADD, 16'h0005, 16'h0007);
		tick(); // First edge that sees opReq high
		cycles = 0;
		while (!resReq && cycles < 10) begin
			tick();
			cycles++;
		end
		checkValue("latency resReq cycles", 16'd2, 16'(cycles));
		finishOp();
		takeResult(gotRes, gotFlags, gotWb);
		checkResult("latency ADD", `ALU_OPX_ADD, 16'h0005, 16'h0007, gotRes, gotFlags, gotWb);
	endtask

	task automatic testBackPressure();
		logic [15:0] res1;
		logic [3:0] flg1;
		logic wb1;
		logic [15:0] res2;
		logic [3:0] flg2;
		logic wb2;
		sendOp(`ALU_OPX_MUL, 16'h0123, 16'h0045); // Result left pending
		raiseOp(`ALU_OPX_SUB, 16'h0010, 16'h0020);
		holdAckLow = 1'b1;
		repeat (10) begin
			tick();
		end
		takeResult(res1, flg1, wb1);
		holdAckLow = 1'b0;
		finishOp();
		takeResult(res2, flg2, wb2);
		checkResult("backPressure first", `ALU_OPX_MUL, 16'h0123, 16'h0045, res1, flg1, wb1);
		checkResult("backPressure second", `ALU_OPX_SUB, 16'h0010, 16'h0020, res2, flg2, wb2);
	endtask

	task automatic testRandom(input int count);
		logic [3:0] op;
		logic [15:0] a;
		logic [15:0] b;
		int k;
		for (k = 0; k < count; k++) begin
			op = 4'($urandom_range(15, 0));
			a = 16'($urandom);
			b = 16'($urandom);
			runOp("random", op, a, b);
		end
	endtask

	initial begin
		rstN = 1'b0;
		opReq = 1'b0;
		opCode = '0;
		opA = '0;
		opB = '0;
		resAck = 1'b0;
		holdAckLow = 1'b0;
		void'($urandom(52));
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		testReset();
		testCorners();
		testLatency();
		testBackPressure();
		testRandom(200);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- forthAlu.f
+incdir+source
+incdir+tb
source/aluPkg.sv
source/aluIssue.sv
source/alu.sv
source/aluRetire.sv
source/aluUnit.sv
tb/aluUnit_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = aluUnit_tb
FILELIST = forthAlu.f
OBJDIR = obj_dir
PASS_MSG = All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
